// ==== include/lfAdder_consts.svh ====
`ifndef LFADDER_CONSTS_SVH
`define LFADDER_CONSTS_SVH

//////////////////////////////
// datapath
//////////////////////////////

// operand and sum width in bits
`define LF_WIDTH 32

//////////////////////////////
// pipeline shape
//////////////////////////////

// pairing level plus four sparse levels
`define LF_LEVELS 5

// pg stage, five prefix levels and the sum stage
`define LF_LATENCY 7

`endif

// ==== hw/lfAdderDataPkg.sv ====
`include "lfAdder_consts.svh"

package lfAdderDataPkg;

	//////////////////////////////
	// operand side
	//////////////////////////////

	// one operand or sum word
	typedef logic [`LF_WIDTH-1:0] wordT;

	// carry-in and carry-out
	typedef logic carryT;

endpackage

// ==== hw/lfAdderPrefixPkg.sv ====
`include "lfAdder_consts.svh"

package lfAdderPrefixPkg;

	//////////////////////////////
	// prefix network
	//////////////////////////////

	// group generate or propagate, one bit per position
	typedef logic [`LF_WIDTH-1:0] pgVecT;

	// index of a prefix level, 0 is the pairing level
	typedef logic [$clog2(`LF_LEVELS)-1:0] levelT;

endpackage

// ==== hw/pgGenerate.sv ====
`timescale 1ns/100ps

module pgGenerate import lfAdderDataPkg::*, lfAdderPrefixPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  wordT  a,
	input  wordT  b,
	input  carryT cin,
	output pgVecT g,
	output pgVecT p,
	output pgVecT halfSum,
	output carryT cinOut
);

	pgVecT bitGen;
	pgVecT bitProp;
	pgVecT gNext;
	pgVecT pNext;

	//////////////////////////////
	// bitwise generate/propagate
	//////////////////////////////

	assign bitGen  = a & b;
	assign bitProp = a ^ b;

	always_comb begin
		gNext = bitGen;
		pNext = bitProp;
		// bit 0 also carries out when cin ripples through it
		gNext[0] = bitGen[0] | (bitProp[0] & cin);
		// group ending at bit 0 is fully resolved
		pNext[0] = 1'b0;
	end

	//////////////////////////////
	// stage register
	//////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			g       <= '0;
			p       <= '0;
			halfSum <= '0;
			cinOut  <= 1'b0;
		end else begin
			g       <= gNext;
			p       <= pNext;
			// plain xor kept for the sum stage
			halfSum <= bitProp;
			cinOut  <= cin;
		end
	end

endmodule

// ==== hw/prefixLevel.sv ====
`timescale 1ns/100ps
`include "lfAdder_consts.svh"

module prefixLevel import lfAdderDataPkg::*, lfAdderPrefixPkg::*; #(
	parameter levelT level = '0
) (
	input  logic  clk,
	input  logic  arstN,
	input  pgVecT gIn,
	input  pgVecT pIn,
	input  pgVecT halfSumIn,
	input  carryT cinIn,
	output pgVecT gOut,
	output pgVecT pOut,
	output pgVecT halfSumOut,
	output carryT cinOut
);

	// distance covered by one group at this level
	localparam int Span = 1 << level;

	// low index bits cleared to find the block base
	localparam int LowMask = (Span << 1) - 1;

	pgVecT gNext;
	pgVecT pNext;

	//////////////////////////////
	// prefix cells
	//////////////////////////////

	// level 0 pairs every odd position with the even one below
	// level k serves odd positions with index bit k set
	genvar i;
	generate
		for (i = 0; i < `LF_WIDTH; i++) begin : genPos
			localparam int Base = i & ~LowMask;
			localparam int Src = Base + Span - 1;
			localparam bit Active = ((i % 2) == 1) && (((i >> level) & 1) == 1);

			if (Active && (Base == 0)) begin : genGray
				// source group reaches bit 0 so only g is needed
				assign gNext[i] = gIn[i] | (pIn[i] & gIn[Src]);
				assign pNext[i] = pIn[i];
			end else if (Active) begin : genBlack
				assign gNext[i] = gIn[i] | (pIn[i] & gIn[Src]);
				assign pNext[i] = pIn[i] & pIn[Src];
			end else begin : genPass
				assign gNext[i] = gIn[i];
				assign pNext[i] = pIn[i];
			end
		end
	endgenerate

	//////////////////////////////
	// stage register
	//////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			gOut <= '0;
			pOut <= '0;
		end else begin
			gOut <= gNext;
			pOut <= pNext;
		end
	end

	// side data riding along with its vector
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halfSumOut <= '0;
			cinOut     <= 1'b0;
		end else begin
			halfSumOut <= halfSumIn;
			cinOut     <= cinIn;
		end
	end

endmodule

// ==== hw/carryResolve.sv ====
`timescale 1ns/100ps
`include "lfAdder_consts.svh"

module carryResolve import lfAdderDataPkg::*, lfAdderPrefixPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  pgVecT gIn,
	input  pgVecT pIn,
	input  pgVecT halfSumIn,
	input  carryT cinIn,
	output wordT  sum,
	output carryT cout
);

	// carry out of each position
	pgVecT carry;
	wordT  sumNext;

	//////////////////////////////
	// even position fill
	//////////////////////////////

	// odd positions and bit 0 are already complete here
	genvar i;
	generate
		for (i = 0; i < `LF_WIDTH; i++) begin : genCarry
			if (((i % 2) == 0) && (i >= 2)) begin : genFill
				assign carry[i] = gIn[i] | (pIn[i] & gIn[i-1]);
			end else begin : genKeep
				assign carry[i] = gIn[i];
			end
		end
	endgenerate

	//////////////////////////////
	// sum
	//////////////////////////////

	// bit 0 sees cin, bit i sees the carry of bit i-1
	assign sumNext = halfSumIn ^ {carry[`LF_WIDTH-2:0], cinIn};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sum  <= '0;
			cout <= 1'b0;
		end else begin
			sum  <= sumNext;
			cout <= carry[`LF_WIDTH-1];
		end
	end

endmodule

// ==== hw/lfAdderTop.sv ====
`timescale 1ns/100ps

module lfAdderTop import lfAdderDataPkg::*, lfAdderPrefixPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  wordT  a,
	input  wordT  b,
	input  carryT cin,
	output wordT  sum,
	output carryT cout
);

	// pg stage outputs
	pgVecT gPg;
	pgVecT pPg;
	pgVecT hsPg;
	carryT cinPg;

	// prefix level outputs
	pgVecT gL0;
	pgVecT pL0;
	pgVecT hsL0;
	carryT cinL0;

	pgVecT gL1;
	pgVecT pL1;
	pgVecT hsL1;
	carryT cinL1;

	pgVecT gL2;
	pgVecT pL2;
	pgVecT hsL2;
	carryT cinL2;

	pgVecT gL3;
	pgVecT pL3;
	pgVecT hsL3;
	carryT cinL3;

	pgVecT gL4;
	pgVecT pL4;
	pgVecT hsL4;
	carryT cinL4;

	//////////////////////////////
	// stage 0
	//////////////////////////////

	pgGenerate i_pg (
		.clk     (clk),
		.arstN   (arstN),
		.a       (a),
		.b       (b),
		.cin     (cin),
		.g       (gPg),
		.p       (pPg),
		.halfSum (hsPg),
		.cinOut  (cinPg)
	);

	//////////////////////////////
	// prefix tree
	//////////////////////////////

	// pairing level
	prefixLevel #(.level(3'd0)) i_level0 (
		.clk        (clk),
		.arstN      (arstN),
		.gIn        (gPg),
		.pIn        (pPg),
		.halfSumIn  (hsPg),
		.cinIn      (cinPg),
		.gOut       (gL0),
		.pOut       (pL0),
		.halfSumOut (hsL0),
		.cinOut     (cinL0)
	);

	// sparse levels, odd positions only
	prefixLevel #(.level(3'd1)) i_level1 (
		.clk        (clk),
		.arstN      (arstN),
		.gIn        (gL0),
		.pIn        (pL0),
		.halfSumIn  (hsL0),
		.cinIn      (cinL0),
		.gOut       (gL1),
		.pOut       (pL1),
		.halfSumOut (hsL1),
		.cinOut     (cinL1)
	);

	prefixLevel #(.level(3'd2)) i_level2 (
		.clk        (clk),
		.arstN      (arstN),
		.gIn        (gL1),
		.pIn        (pL1),
		.halfSumIn  (hsL1),
		.cinIn      (cinL1),
		.gOut       (gL2),
		.pOut       (pL2),
		.halfSumOut (hsL2),
		.cinOut     (cinL2)
	);

	prefixLevel #(.level(3'd3)) i_level3 (
		.clk        (clk),
		.arstN      (arstN),
		.gIn        (gL2),
		.pIn        (pL2),
		.halfSumIn  (hsL2),
		.cinIn      (cinL2),
		.gOut       (gL3),
		.pOut       (pL3),
		.halfSumOut (hsL3),
		.cinOut     (cinL3)
	);

	prefixLevel #(.level(3'd4)) i_level4 (
		.clk        (clk),
		.arstN      (arstN),
		.gIn        (gL3),
		.pIn        (pL3),
		.halfSumIn  (hsL3),
		.cinIn      (cinL3),
		.gOut       (gL4),
		.pOut       (pL4),
		.halfSumOut (hsL4),
		.cinOut     (cinL4)
	);

	//////////////////////////////
	// final stage
	//////////////////////////////

	carryResolve i_resolve (
		.clk       (clk),
		.arstN     (arstN),
		.gIn       (gL4),
		.pIn       (pL4),
		.halfSumIn (hsL4),
		.cinIn     (cinL4),
		.sum       (sum),
		.cout      (cout)
	);

endmodule

// ==== tb/lfAdderChecker.sv ====
`timescale 1ns/100ps
`include "lfAdder_consts.svh"

module lfAdderChecker import lfAdderDataPkg::*; (
	input  logic  clk,
	input  logic  arstN,
	input  logic  expValid,
	input  int    expIdx,
	input  wordT  expSum,
	input  carryT expCout,
	input  wordT  sum,
	input  carryT cout,
	output int    errorCount,
	output int    checkCount
);

	// expected values ride along with the DUT pipeline
	logic  validPipe [`LF_LATENCY];
	int    idxPipe   [`LF_LATENCY];
	wordT  sumPipe   [`LF_LATENCY];
	carryT coutPipe  [`LF_LATENCY];

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `LF_LATENCY; k++) begin
				validPipe[k] <= 1'b0;
			end
		end else begin
			validPipe[0] <= expValid;
			idxPipe[0]   <= expIdx;
			sumPipe[0]   <= expSum;
			coutPipe[0]  <= expCout;
			for (int k = 1; k < `LF_LATENCY; k++) begin
				validPipe[k] <= validPipe[k-1];
				idxPipe[k]   <= idxPipe[k-1];
				sumPipe[k]   <= sumPipe[k-1];
				coutPipe[k]  <= coutPipe[k-1];
			end
		end
	end

	task automatic compareVector(input int idx, input wordT es, input carryT ec);
		checkCount++;
		if (sum !== es || cout !== ec) begin
			errorCount++;
			$display("Error at %0t: vector %0d expected sum %h cout %b, got sum %h cout %b",
				$time, idx, es, ec, sum, cout);
		end
	endtask

	task automatic expectZero(input string phase);
		checkCount++;
		if (sum !== '0 || cout !== 1'b0) begin
			errorCount++;
			$display("Error at %0t: %s, expected sum 0 cout 0, got sum %h cout %b",
				$time, phase, sum, cout);
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!arstN) begin
			expectZero("in reset");
		end else if (validPipe[`LF_LATENCY-1]) begin
			compareVector(idxPipe[`LF_LATENCY-1], sumPipe[`LF_LATENCY-1],
				coutPipe[`LF_LATENCY-1]);
		end else begin
			expectZero("no vector arrived yet");
		end
	end

endmodule

// ==== tb/lfAdder_props.sv ====
`timescale 1ns/100ps
`include "lfAdder_consts.svh"

module lfAdderProps import lfAdderDataPkg::*; (
	input logic  clk,
	input logic  arstN,
	input wordT  a,
	input wordT  b,
	input carryT cin,
	input wordT  sum,
	input carryT cout
);

	// failures seen so far, read at the end of the run
	int failCount = 0;

	// edges since reset release, saturating
	int settled;

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			settled <= 0;
		end else if (settled < `LF_LATENCY) begin
			settled <= settled + 1;
		end
	end

	// mid-cycle sample so the async clear has always landed
	resetZero: assert property (@(negedge clk) !arstN |-> (sum == '0 && cout == 1'b0))
		else begin
			$error("sum or cout nonzero while reset is held");
			failCount++;
		end

	noUnknown: assert property (@(posedge clk) disable iff (!arstN)
		!$isunknown({sum, cout}))
		else begin
			$error("sum or cout unknown after reset");
			failCount++;
		end

	// whole pipeline refilled since the last reset
	sumMatches: assert property (@(posedge clk) disable iff (!arstN)
		(settled >= `LF_LATENCY) |-> ({cout, sum} == ({1'b0, $past(a, `LF_LATENCY)}
			+ $past(b, `LF_LATENCY) + $past(cin, `LF_LATENCY))))
		else begin
			$error("sum and cout differ from the operands seven cycles earlier");
			failCount++;
		end

endmodule

bind lfAdderTop lfAdderProps i_props (.*);

// ==== tb/lfAdderTb.sv ====
`timescale 1ns/100ps
`include "lfAdder_consts.svh"

module lfAdderTb import lfAdderDataPkg::*; ();

	localparam int NumRandom   = 200;
	localparam int MaxDirected = 64;
	localparam int Fields      = 5;

	// starts low without an edge at time zero
	logic  clk = 1'b0;
	logic  arstN;
	wordT  a;
	wordT  b;
	carryT cin;
	wordT  sum;
	carryT cout;

	// expected result handed to the checker with its vector
	logic  expValid;
	int    expIdx;
	wordT  expSum;
	carryT expCout;

	logic [31:0] dataMem [0:MaxDirected*Fields-1];
	logic [31:0] seed;
	int numDirected;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int checkCount;
	int totalErrors;

	lfAdderTop i_dut (
		.clk   (clk),
		.arstN (arstN),
		.a     (a),
		.b     (b),
		.cin   (cin),
		.sum   (sum),
		.cout  (cout)
	);

	lfAdderChecker i_check (
		.clk        (clk),
		.arstN      (arstN),
		.expValid   (expValid),
		.expIdx     (expIdx),
		.expSum     (expSum),
		.expCout    (expCout),
		.sum        (sum),
		.cout       (cout),
		.errorCount (errorCount),
		.checkCount (checkCount)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic clearInputs();
		a = '0;
		b = '0;
		cin = 1'b0;
		expValid = 1'b0;
	endtask

	task automatic driveVector(input wordT va, input wordT vb, input carryT vc,
		input wordT es, input carryT ec, input int idx);
		@(posedge clk);
		#1;
		a = va;
		b = vb;
		cin = vc;
		expSum = es;
		expCout = ec;
		expIdx = idx;
		expValid = 1'b1;
	endtask

	task automatic driveIdle();
		@(posedge clk);
		#1;
		clearInputs();
	endtask

	// arstN low while earlier vectors are still in flight
	task automatic pulseReset(input int cycles);
		@(posedge clk);
		#1;
		clearInputs();
		arstN = 1'b0;
		repeat (cycles) @(posedge clk);
		#1;
		arstN = 1'b1;
	endtask

	task automatic runRandom(input int count, input int firstIdx);
		logic [32:0] total;
		wordT ra;
		wordT rb;
		carryT rc;
		for (int i = 0; i < count; i++) begin
			seed = nextRandom(seed);
			ra = seed;
			seed = nextRandom(seed);
			rb = seed;
			seed = nextRandom(seed);
			rc = seed[31];
			total = {1'b0, ra} + {1'b0, rb} + {32'b0, rc};
			driveVector(ra, rb, rc, total[31:0], total[32], firstIdx + i);
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		arstN = 1'b0;
		clearInputs();
		expSum = '0;
		expCout = 1'b0;
		expIdx = 0;
		seed = 32'd55513;
		$readmemh("tb/lfAdder_testdata.txt", dataMem);
		numDirected = 0;
		while (numDirected < MaxDirected && !$isunknown(dataMem[numDirected*Fields])) begin
			numDirected++;
		end
		cycleLimit = numDirected + NumRandom + `LF_LATENCY + 20;
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;
		for (int k = 0; k < numDirected; k++) begin
			driveVector(dataMem[k*Fields], dataMem[k*Fields+1], dataMem[k*Fields+2][0],
				dataMem[k*Fields+3], dataMem[k*Fields+4][0], k);
		end
		runRandom(NumRandom / 2, numDirected);
		pulseReset(2);
		runRandom(NumRandom / 2, numDirected + NumRandom / 2);
		driveIdle();
		repeat (`LF_LATENCY + 2) @(posedge clk);
		totalErrors = errorCount + i_dut.i_props.failCount;
		$display("closing: %0d errors (%0d compare, %0d assertion) in %0d checks",
			totalErrors, errorCount, i_dut.i_props.failCount, checkCount);
		if (totalErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// run length bound
	initial begin
		cycleCount = 0;
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== lfAdder.f ====
+incdir+include
hw/lfAdderDataPkg.sv
hw/lfAdderPrefixPkg.sv
hw/pgGenerate.sv
hw/prefixLevel.sv
hw/carryResolve.sv
hw/lfAdderTop.sv
tb/lfAdderChecker.sv
tb/lfAdder_props.sv
tb/lfAdderTb.sv

// ==== tb/lfAdder_testdata.txt ====
// columns: A  B  Cin  expected sum  expected Cout, all hex
// one vector per line, driven back to back in this order
00000000 00000000 0 00000000 0
FFFFFFFF 00000000 1 00000000 1
FFFFFFFF FFFFFFFF 1 FFFFFFFF 1
00000001 00000001 0 00000002 0
00000003 00000001 0 00000004 0
00000001 00000000 1 00000002 0
FFFFFFFF 00000001 0 00000000 1
80000000 80000000 0 00000000 1
7FFFFFFF 00000001 0 80000000 0
12345678 87654321 0 99999999 0
12345678 87654321 1 9999999A 0
AAAAAAAA 55555555 0 FFFFFFFF 0
AAAAAAAA 55555555 1 00000000 1
0000FFFF 00000001 0 00010000 0
FFFF0000 00010000 0 00000000 1
DEADBEEF 00000001 1 DEADBEF1 0
00000000 00000000 1 00000001 0
FFFFFFFE 00000001 1 00000000 1
0F0F0F0F F0F0F0F0 1 00000000 1
13579BDF 02468ACE 0 159E26AD 0
80000001 80000001 1 00000003 1
55555555 55555555 0 AAAAAAAA 0
CAFEBABE 35014541 1 00000000 1
00000001 00000001 1 00000003 0
